// ==== filelist.f ====
+incdir+src
src/backend_pkg.sv
src/rename_table.sv
src/rob.sv
src/reservation_station.sv
src/alu.sv
src/mul_ctrl.sv
src/iteration_counter.sv
src/mul_datapath.sv
src/backend_top.sv
test/backend_properties.sv
test/backend_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module backend_tb -f filelist.f -o backend_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/backend_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "Done: no errors" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== test/backend_tb.sv ====
`include "backend_settings.svh"

module backend_tb
    import backend_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MODE_LI     = 0;
    localparam int MODE_ALU    = 1;
    localparam int MODE_MIX    = 2;
    localparam int MODE_BURST  = 3;
    localparam int HOLD_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;

    typedef struct packed {
        logic [`AREG_W-1:0] rd;
        logic [`TAG_W-1:0]  tag;
        logic [`XLEN-1:0]   value;
    } expect_t;

    logic               clk;
    logic               rst_n_i;
    logic               dispatch_valid_i;
    uop_t               dispatch_uop_i;
    logic               dispatch_ready_o;
    commit_t            commit_o;

    logic [31:0]        lfsr_q;
    logic [`XLEN-1:0]   model_regs [`ARCH_REGS];
    expect_t            expect_q [$];
    int unsigned        accepted;
    int unsigned        committed;
    int unsigned        errors;
    int unsigned        timeouts;

    backend_top DUT (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_uop_i     (dispatch_uop_i),
        .dispatch_ready_o   (dispatch_ready_o),
        .commit_o           (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [`XLEN-1:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            bits   = {bits[`XLEN-2:0], lfsr_q[0]};
        end
    endtask

    // sequential reference, one op at a time in program order
    function automatic logic [`XLEN-1:0] model_result(uop_t u);
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [2*`XLEN-1:0] prod;
        a    = model_regs[u.rs1];
        b    = model_regs[u.rs2];
        prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        case (u.op)
            LI:      return u.imm;
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            XOR:     return a ^ b;
            MUL:     return prod[`XLEN-1:0];
            default: return '0;
        endcase
    endfunction

    task automatic make_uop(input int mode, output uop_t u);
        logic [`XLEN-1:0] bits;
        int               reg_bits;
        // narrow register range in some phases to force dependencies
        reg_bits = (mode == MODE_ALU) ? 2 : 3;
        take_bits(3, bits);
        case (mode)
            MODE_LI:  u.op = LI;
            MODE_ALU: u.op = op_e'(3'(bits % 16'd5));
            MODE_MIX: u.op = op_e'(3'(bits % 16'd6));
            // fast ops pile up behind each slow multiply
            default:  u.op = (bits[1:0] == 2'd0) ? MUL : ADD;
        endcase
        take_bits(reg_bits, bits);
        u.rd = bits[`AREG_W-1:0];
        take_bits(reg_bits, bits);
        u.rs1 = bits[`AREG_W-1:0];
        take_bits(reg_bits, bits);
        u.rs2 = bits[`AREG_W-1:0];
        take_bits(`XLEN, bits);
        u.imm = bits;
    endtask

    task automatic accept_uop(input uop_t u);
        expect_t     e;
        int unsigned tag_val;
        tag_val = accepted % `ROB_DEPTH;
        e.rd    = u.rd;
        e.tag   = tag_val[`TAG_W-1:0];
        e.value = model_result(u);
        model_regs[u.rd] = e.value;
        expect_q.push_back(e);
        accepted++;
    endtask

    task automatic check_commit();
        expect_t e;
        if (expect_q.size() == 0) begin
            $display("commit seen with no op in flight, tag %h", commit_o.tag);
            errors++;
        end else begin
            e = expect_q.pop_front();
            if (commit_o.rd !== e.rd) begin
                $display("[ERROR] commit_o.rd expected %h got %h", e.rd, commit_o.rd);
                errors++;
            end
            if (commit_o.value !== e.value) begin
                $display("[ERROR] commit_o.value expected %h got %h", e.value, commit_o.value);
                errors++;
            end
            if (commit_o.tag !== e.tag) begin
                $display("[ERROR] commit_o.tag expected %h got %h", e.tag, commit_o.tag);
                errors++;
            end
        end
        committed++;
    endtask

    // sample mid-cycle and move on to the next drive point
    task automatic sample_cycle(output logic fired);
        fired = 1'b0;
        @(negedge clk);
        if (accepted - committed == `ROB_DEPTH && dispatch_ready_o !== 1'b0) begin
            $display("[ERROR] dispatch_ready_o expected %h got %h", 1'b0, dispatch_ready_o);
            errors++;
        end
        if (commit_o.valid) begin
            check_commit();
        end
        if (dispatch_valid_i && dispatch_ready_o) begin
            fired = 1'b1;
            accept_uop(dispatch_uop_i);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic check_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (commit_o.valid !== 1'b0) begin
                $display("[ERROR] commit_o.valid expected %h got %h", 1'b0, commit_o.valid);
                errors++;
            end
            if (dispatch_ready_o !== 1'b1) begin
                $display("[ERROR] dispatch_ready_o expected %h got %h", 1'b1, dispatch_ready_o);
                errors++;
            end
            @(posedge clk);
            #10;
        end
    endtask

    task automatic send_ops(input int mode, input int n);
        uop_t u;
        logic fired;
        int   hold;
        for (int i = 0; i < n; i++) begin
            make_uop(mode, u);
            dispatch_valid_i = 1'b1;
            dispatch_uop_i   = u;
            fired = 1'b0;
            hold  = 0;
            // uop stays on the port until accepted
            while (!fired && hold < HOLD_LIMIT) begin
                sample_cycle(fired);
                hold++;
            end
            if (!fired) begin
                $display("timeout: uop not accepted within %0d cycles", HOLD_LIMIT);
                timeouts++;
                break;
            end
        end
        dispatch_valid_i = 1'b0;
        dispatch_uop_i   = '0;
    endtask

    task automatic drain();
        logic fired;
        int   waited;
        waited = 0;
        while (committed != accepted && waited < DRAIN_LIMIT) begin
            sample_cycle(fired);
            waited++;
        end
        if (committed != accepted) begin
            $display("timeout: %0d ops still in flight after %0d cycles",
                     accepted - committed, DRAIN_LIMIT);
            timeouts++;
        end
    endtask

    initial begin
        logic fired;
        lfsr_q           = 32'd66566;
        accepted         = 0;
        committed        = 0;
        errors           = 0;
        timeouts         = 0;
        rst_n_i          = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_uop_i   = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        #10;
        rst_n_i = 1'b1;

        check_idle(5);
        send_ops(MODE_LI, 8);
        send_ops(MODE_ALU, 60);
        drain();
        send_ops(MODE_MIX, 60);
        drain();
        // mul bursts fill the RS and ROB
        for (int b = 0; b < 4; b++) begin
            send_ops(MODE_BURST, 12);
            drain();
        end
        // no stray commits once empty
        repeat (20) sample_cycle(fired);

        $display("accepted %0d committed %0d errors %0d timeouts %0d assertion failures %0d",
                 accepted, committed, errors, timeouts, DUT.props_i.fail_count);
        if (errors == 0 && timeouts == 0 && DUT.props_i.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== test/backend_properties.sv ====
`include "backend_settings.svh"

module backend_properties
    import backend_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    mul_start_i,
    input  cdb_t    bus0_i,
    input  cdb_t    bus1_i,
    input  commit_t commit_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // multiplier result comes XLEN + 1 cycles after its start
    mul_result_latency: assert property (
        @(posedge clk) disable iff (!rst_n_i) bus1_i.valid |-> $past(mul_start_i, `XLEN + 1)
    ) else begin
        $error("bus 1 valid without a multiplier start %0d cycles earlier", `XLEN + 1);
        fail_count++;
    end

    distinct_bus_tags: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(bus0_i.valid && bus1_i.valid && bus0_i.tag == bus1_i.tag)
    ) else begin
        $error("both buses carry tag %h in the same cycle", bus0_i.tag);
        fail_count++;
    end

    commit_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n_i) !$isunknown(commit_i.valid)
    ) else begin
        $error("commit valid is unknown");
        fail_count++;
    end

endmodule

bind backend_top backend_properties props_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .mul_start_i (mul_issue_valid),
    .bus0_i      (cdb[0]),
    .bus1_i      (cdb[1]),
    .commit_i    (commit_o)
);

// ==== src/backend_top.sv ====
`include "backend_settings.svh"

module backend_top
    import backend_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,

    input  logic        dispatch_valid_i,
    input  uop_t        dispatch_uop_i,
    output logic        dispatch_ready_o,

    output commit_t     commit_o
);

    logic               dispatch_fire;
    logic [`TAG_W-1:0]  alloc_tag;
    logic               rs_full;

    operand_t           raw_src1;
    operand_t           raw_src2;
    operand_t           src1;
    operand_t           src2;

    // bus 0 from the ALU, bus 1 from the multiplier
    cdb_t               cdb [`CDB_WIDTH];

    issue_t             alu_issue;
    logic               alu_issue_valid;
    issue_t             mul_issue;
    logic               mul_issue_valid;

    logic               mul_busy;
    logic               mul_step;
    logic               mul_done;
    logic               last_step;

    rename_table rename_table_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .dispatch_fire_i    (dispatch_fire),
        .dispatch_uop_i     (dispatch_uop_i),
        .alloc_tag_i        (alloc_tag),
        .commit_i           (commit_o),
        .src1_o             (raw_src1),
        .src2_o             (raw_src2)
    );

    rob rob_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_ready_o   (dispatch_ready_o),
        .rs_full_i          (rs_full),
        .dispatch_fire_o    (dispatch_fire),
        .dispatch_rd_i      (dispatch_uop_i.rd),
        .alloc_tag_o        (alloc_tag),
        .src1_i             (raw_src1),
        .src2_i             (raw_src2),
        .src1_o             (src1),
        .src2_o             (src2),
        .cdb_i              (cdb),
        .commit_o           (commit_o)
    );

    reservation_station reservation_station_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .dispatch_fire_i    (dispatch_fire),
        .dispatch_op_i      (dispatch_uop_i.op),
        .alloc_tag_i        (alloc_tag),
        .src1_i             (src1),
        .src2_i             (src2),
        .cdb_i              (cdb),
        .mul_busy_i         (mul_busy),
        .rs_full_o          (rs_full),
        .alu_issue_o        (alu_issue),
        .alu_issue_valid_o  (alu_issue_valid),
        .mul_issue_o        (mul_issue),
        .mul_issue_valid_o  (mul_issue_valid)
    );

    alu alu_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .issue_valid_i      (alu_issue_valid),
        .issue_i            (alu_issue),
        .cdb_o              (cdb[0])
    );

    mul_ctrl mul_ctrl_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .start_i            (mul_issue_valid),
        .last_step_i        (last_step),
        .busy_o             (mul_busy),
        .step_o             (mul_step),
        .done_o             (mul_done)
    );

    iteration_counter iteration_counter_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .load_i             (mul_issue_valid),
        .step_i             (mul_step),
        .last_step_o        (last_step)
    );

    mul_datapath mul_datapath_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .start_i            (mul_issue_valid),
        .issue_i            (mul_issue),
        .step_i             (mul_step),
        .done_i             (mul_done),
        .cdb_o              (cdb[1])
    );

endmodule

// ==== src/mul_datapath.sv ====
`include "backend_settings.svh"

module mul_datapath
    import backend_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    start_i,
    input  issue_t  issue_i,
    input  logic    step_i,
    input  logic    done_i,
    output cdb_t    cdb_o
);

    logic [`XLEN-1:0]   mcand_q;
    logic [`XLEN-1:0]   mplier_q;
    logic [`XLEN-1:0]   prod_q;
    logic [`TAG_W-1:0]  tag_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mcand_q  <= '0;
            mplier_q <= '0;
            prod_q   <= '0;
            tag_q    <= '0;
        end else if (start_i) begin
            mcand_q  <= issue_i.a;
            mplier_q <= issue_i.b;
            prod_q   <= '0;
            tag_q    <= issue_i.dst;
        end else if (step_i) begin
            // low half only, upper product bits fall off
            if (mplier_q[0]) begin
                prod_q <= prod_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign cdb_o = '{valid: done_i, tag: tag_q, value: prod_q};

endmodule

// ==== src/iteration_counter.sv ====
`include "backend_settings.svh"

module iteration_counter (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    load_i,
    input  logic    step_i,
    output logic    last_step_o
);

    localparam int CNT_W = $clog2(`XLEN);

    logic [CNT_W-1:0] count_q;

    // one step per multiplier bit
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= CNT_W'(`XLEN - 1);
        end else if (step_i && count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign last_step_o = step_i && (count_q == '0);

endmodule

// ==== src/mul_ctrl.sv ====
module mul_ctrl (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    start_i,
    input  logic    last_step_i,
    output logic    busy_o,
    output logic    step_o,
    output logic    done_o
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e state_q;
    state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = RUN;
            RUN:     if (last_step_i) state_d = DONE;
            // result is on bus 1 for this one cycle
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign busy_o = state_q != IDLE;
    assign step_o = state_q == RUN;
    assign done_o = state_q == DONE;

endmodule

// ==== src/alu.sv ====
`include "backend_settings.svh"

module alu
    import backend_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    issue_valid_i,
    input  issue_t  issue_i,
    output cdb_t    cdb_o
);

    logic [`XLEN-1:0]   result;
    cdb_t               cdb_q;

    always_comb begin
        case (issue_i.op)
            LI:      result = issue_i.b;
            ADD:     result = issue_i.a + issue_i.b;
            SUB:     result = issue_i.a - issue_i.b;
            AND:     result = issue_i.a & issue_i.b;
            XOR:     result = issue_i.a ^ issue_i.b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cdb_q.valid <= 1'b0;
        end else begin
            cdb_q.valid <= issue_valid_i;
        end
        cdb_q.tag   <= issue_i.dst;
        cdb_q.value <= result;
    end

    assign cdb_o = cdb_q;

endmodule

// ==== src/reservation_station.sv ====
`include "backend_settings.svh"

module reservation_station
    import backend_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n_i,

    input  logic                dispatch_fire_i,
    input  op_e                 dispatch_op_i,
    input  logic [`TAG_W-1:0]   alloc_tag_i,
    input  operand_t            src1_i,
    input  operand_t            src2_i,

    input  cdb_t                cdb_i [`CDB_WIDTH],
    input  logic                mul_busy_i,
    output logic                rs_full_o,

    output issue_t              alu_issue_o,
    output logic                alu_issue_valid_o,
    output issue_t              mul_issue_o,
    output logic                mul_issue_valid_o
);

    localparam int IDX_W = $clog2(`RS_DEPTH);

    typedef struct packed {
        op_e                op;
        logic [`TAG_W-1:0]  dst;
        operand_t           src1;
        operand_t           src2;
    } rs_entry_t;

    logic [`RS_DEPTH-1:0]   valid_q;
    rs_entry_t              entry_q [`RS_DEPTH];
    // older_q[i][j] set when entry i was dispatched before entry j
    logic [`RS_DEPTH-1:0]   older_q [`RS_DEPTH];
    logic [`RS_DEPTH-1:0]   alu_ready;
    logic [`RS_DEPTH-1:0]   mul_ready;
    logic [`RS_DEPTH-1:0]   alu_grant;
    logic [`RS_DEPTH-1:0]   mul_grant;
    logic [IDX_W-1:0]       alloc_idx;

    // pick up a result broadcast on either bus
    function automatic operand_t snoop(operand_t src);
        operand_t res;
        res = src;
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (!res.ready && cdb_i[k].valid && cdb_i[k].tag == res.tag) begin
                res.ready = 1'b1;
                res.value = cdb_i[k].value;
            end
        end
        return res;
    endfunction

    assign rs_full_o = &valid_q;

    // lowest free slot
    always_comb begin
        alloc_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                alloc_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            alu_ready[i] = valid_q[i] && entry_q[i].src1.ready && entry_q[i].src2.ready
                           && entry_q[i].op != MUL;
            mul_ready[i] = valid_q[i] && entry_q[i].src1.ready && entry_q[i].src2.ready
                           && entry_q[i].op == MUL && !mul_busy_i;
        end
    end

    // oldest ready entry per unit
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            alu_grant[i] = alu_ready[i];
            mul_grant[i] = mul_ready[i];
            for (int j = 0; j < `RS_DEPTH; j++) begin
                if (older_q[j][i] && alu_ready[j]) begin
                    alu_grant[i] = 1'b0;
                end
                if (older_q[j][i] && mul_ready[j]) begin
                    mul_grant[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        alu_issue_o = '0;
        mul_issue_o = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (alu_grant[i]) begin
                alu_issue_o = '{op: entry_q[i].op, dst: entry_q[i].dst,
                                a: entry_q[i].src1.value, b: entry_q[i].src2.value};
            end
            if (mul_grant[i]) begin
                mul_issue_o = '{op: entry_q[i].op, dst: entry_q[i].dst,
                                a: entry_q[i].src1.value, b: entry_q[i].src2.value};
            end
        end
    end

    assign alu_issue_valid_o = |alu_grant;
    assign mul_issue_valid_o = |mul_grant;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < `RS_DEPTH; i++) begin
                older_q[i] <= '0;
            end
        end else begin
            valid_q <= valid_q & ~alu_grant & ~mul_grant;
            if (dispatch_fire_i) begin
                valid_q[alloc_idx]   <= 1'b1;
                older_q[alloc_idx]   <= '0;
                for (int j = 0; j < `RS_DEPTH; j++) begin
                    older_q[j][alloc_idx] <= valid_q[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            entry_q[i].src1 <= snoop(entry_q[i].src1);
            entry_q[i].src2 <= snoop(entry_q[i].src2);
        end
        if (dispatch_fire_i) begin
            entry_q[alloc_idx].op   <= dispatch_op_i;
            entry_q[alloc_idx].dst  <= alloc_tag_i;
            entry_q[alloc_idx].src1 <= snoop(src1_i);
            entry_q[alloc_idx].src2 <= snoop(src2_i);
        end
    end

endmodule

// ==== src/rob.sv ====
`include "backend_settings.svh"

module rob
    import backend_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n_i,

    input  logic                dispatch_valid_i,
    output logic                dispatch_ready_o,
    input  logic                rs_full_i,
    output logic                dispatch_fire_o,
    input  logic [`AREG_W-1:0]  dispatch_rd_i,
    output logic [`TAG_W-1:0]   alloc_tag_o,

    input  operand_t            src1_i,
    input  operand_t            src2_i,
    output operand_t            src1_o,
    output operand_t            src2_o,

    input  cdb_t                cdb_i [`CDB_WIDTH],
    output commit_t             commit_o
);

    localparam int CNT_W = `TAG_W + 1;

    logic [`TAG_W-1:0]      head_q;
    logic [`TAG_W-1:0]      tail_q;
    logic [CNT_W-1:0]       count_q;
    logic [`ROB_DEPTH-1:0]  done_q;
    logic [`AREG_W-1:0]     rd_q [`ROB_DEPTH];
    logic [`XLEN-1:0]       value_q [`ROB_DEPTH];
    logic                   retire;

    // waiting operand whose producer already finished
    function automatic operand_t resolve(operand_t src);
        operand_t res;
        res = src;
        if (!src.ready && done_q[src.tag]) begin
            res.ready = 1'b1;
            res.value = value_q[src.tag];
        end
        return res;
    endfunction

    assign dispatch_ready_o = (count_q < CNT_W'(`ROB_DEPTH)) && !rs_full_i;
    assign dispatch_fire_o  = dispatch_valid_i && dispatch_ready_o;
    assign alloc_tag_o      = tail_q;

    assign src1_o = resolve(src1_i);
    assign src2_o = resolve(src2_i);

    assign retire = (count_q != '0) && done_q[head_q];

    always_comb begin
        commit_o.valid = retire;
        commit_o.tag   = head_q;
        commit_o.rd    = rd_q[head_q];
        commit_o.value = value_q[head_q];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (dispatch_fire_o) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(dispatch_fire_o) - CNT_W'(retire);
            for (int k = 0; k < `CDB_WIDTH; k++) begin
                if (cdb_i[k].valid) begin
                    done_q[cdb_i[k].tag] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire_o) begin
            rd_q[tail_q] <= dispatch_rd_i;
        end
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (cdb_i[k].valid) begin
                value_q[cdb_i[k].tag] <= cdb_i[k].value;
            end
        end
    end

endmodule

// ==== src/rename_table.sv ====
`include "backend_settings.svh"

module rename_table
    import backend_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n_i,

    input  logic                dispatch_fire_i,
    input  uop_t                dispatch_uop_i,
    input  logic [`TAG_W-1:0]   alloc_tag_i,

    input  commit_t             commit_i,

    output operand_t            src1_o,
    output operand_t            src2_o
);

    logic [`ARCH_REGS-1:0]  busy_q;
    logic [`TAG_W-1:0]      map_q [`ARCH_REGS];
    logic [`XLEN-1:0]       arf_q [`ARCH_REGS];

    function automatic operand_t lookup(logic [`AREG_W-1:0] r);
        operand_t res;
        res.ready = !busy_q[r];
        res.tag   = map_q[r];
        res.value = arf_q[r];
        return res;
    endfunction

    always_comb begin
        src1_o = lookup(dispatch_uop_i.rs1);
        src2_o = lookup(dispatch_uop_i.rs2);
        // load immediate has no register sources
        if (dispatch_uop_i.op == LI) begin
            src1_o = '{ready: 1'b1, tag: '0, value: '0};
            src2_o = '{ready: 1'b1, tag: '0, value: dispatch_uop_i.imm};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= '0;
            for (int i = 0; i < `ARCH_REGS; i++) begin
                arf_q[i] <= '0;
            end
        end else begin
            if (commit_i.valid) begin
                arf_q[commit_i.rd] <= commit_i.value;
                // a younger writer keeps the register busy
                if (map_q[commit_i.rd] == commit_i.tag) begin
                    busy_q[commit_i.rd] <= 1'b0;
                end
            end
            // same-cycle dispatch to rd wins over the commit
            if (dispatch_fire_i) begin
                busy_q[dispatch_uop_i.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire_i) begin
            map_q[dispatch_uop_i.rd] <= alloc_tag_i;
        end
    end

endmodule

// ==== src/backend_pkg.sv ====
`include "backend_settings.svh"

package backend_pkg;

    typedef enum logic [2:0] {
        LI,
        ADD,
        SUB,
        AND,
        XOR,
        MUL
    } op_e;

    typedef struct packed {
        op_e                op;
        logic [`AREG_W-1:0] rd;
        logic [`AREG_W-1:0] rs1;
        logic [`AREG_W-1:0] rs2;
        logic [`XLEN-1:0]   imm;
    } uop_t;

    // value only meaningful once ready is set
    typedef struct packed {
        logic               ready;
        logic [`TAG_W-1:0]  tag;
        logic [`XLEN-1:0]   value;
    } operand_t;

    typedef struct packed {
        logic               valid;
        logic [`TAG_W-1:0]  tag;
        logic [`XLEN-1:0]   value;
    } cdb_t;

    typedef struct packed {
        logic               valid;
        logic [`TAG_W-1:0]  tag;
        logic [`AREG_W-1:0] rd;
        logic [`XLEN-1:0]   value;
    } commit_t;

    typedef struct packed {
        op_e                op;
        logic [`TAG_W-1:0]  dst;
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
    } issue_t;

endpackage

// ==== src/backend_settings.svh ====
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// datapath width
`define XLEN        16

// architectural registers
`define ARCH_REGS   8
`define AREG_W      3

// reorder buffer, tag is the entry index
`define ROB_DEPTH   8
`define TAG_W       3

// issue queue and result buses
`define RS_DEPTH    4
`define CDB_WIDTH   2

`endif
